//--- logic/fetch_pkg.sv
// Shared widths, region constants and bus types for the fetch side
// Single-way I-cache, one 64-bit window per bus beat, identity translation
// Code region must be a multiple of the line size and aligned to it
package fetch_pkg;

   localparam int unsigned AW          = 32;   // Address width
   localparam int unsigned INSN_W      = 32;
   localparam int unsigned FETCH_LANES = 2;    // Instructions per window
   localparam int unsigned WIN_BYTES   = 8;
   localparam int unsigned BUS_DW      = 64;   // One window per beat

   localparam int unsigned LINE_BYTES  = 32;
   localparam int unsigned LINE_BEATS  = 4;
   localparam int unsigned IC_SETS     = 32;
   localparam int unsigned IC_WAYS     = 1;    // Direct mapped
   localparam int unsigned IC_LINES    = IC_WAYS * IC_SETS;
   localparam int unsigned PAGE_BITS   = 12;

   localparam logic [AW-1:0] RESET_PC     = 32'h0000_0000;
   localparam logic [AW-1:0] REGION_BYTES = 32'd1024;   // Same as cache size

   // Derived field widths
   localparam int unsigned WIN_OFF_W = $clog2(WIN_BYTES);
   localparam int unsigned IC_OFF_W  = $clog2(LINE_BYTES);
   localparam int unsigned IC_IDX_W  = $clog2(IC_SETS);
   localparam int unsigned IC_TAG_W  = AW - IC_IDX_W - IC_OFF_W;
   localparam int unsigned BEAT_W    = $clog2(LINE_BEATS);
   localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(LINE_BEATS - 1);

   // Bus ids
   localparam int unsigned ID_W = 1;
   localparam logic [ID_W-1:0] ID_FETCH = 1'b0;
   localparam logic [ID_W-1:0] ID_LOAD  = 1'b1;

   // Cache view of an address
   typedef struct packed {
      logic [IC_TAG_W-1:0] tag;
      logic [IC_IDX_W-1:0] idx;
      logic [IC_OFF_W-1:0] off;
   } ic_addr_t;

   // Page view, index bits sit inside the page offset
   typedef struct packed {
      logic [AW-PAGE_BITS-1:0] ppn;
      logic [PAGE_BITS-1:0]    vpo;
   } page_addr_t;

   typedef union packed {
      ic_addr_t   ic;
      page_addr_t pg;
   } fetch_addr_u;

   typedef struct packed {
      logic                                valid;
      logic [AW-1:0]                       addr;   // Window base
      logic [FETCH_LANES-1:0][INSN_W-1:0] insn;   // Lane 0 at lower address
   } fetch_window_t;

   typedef struct packed {
      logic              valid;
      logic [AW-1:0]     addr;
      logic [BEAT_W-1:0] len;    // Beats minus one
      logic [ID_W-1:0]   id;
   } rd_ar_t;

   typedef struct packed {
      logic              valid;
      logic [BUS_DW-1:0] data;
      logic              last;
      logic [ID_W-1:0]   id;
   } rd_r_t;

endpackage

//--- logic/fetch_pc_gen.sv
// Linear fetch PC, one window per cycle, no branch redirect
// PC wraps to RESET_PC at the end of the code region
// Lookup address is the next PC, so a stall replays the held window
`timescale 1ns/1ps

module fetch_pc_gen (
   input  logic                   clk,
   input  logic                   rst_i,
   input  logic                   stall_i,        // From I-cache stage 2
   output fetch_pkg::fetch_addr_u fetch_vaddr_o   // Stage 1 lookup address
);

   // First address past the region
   localparam logic [fetch_pkg::AW-1:0] REGION_END =
      fetch_pkg::RESET_PC + fetch_pkg::REGION_BYTES;
   // Last window of the region, so the first lookup is RESET_PC
   localparam logic [fetch_pkg::AW-1:0] PC_INIT =
      REGION_END - fetch_pkg::WIN_BYTES;

   logic [fetch_pkg::AW-1:0] pc;
   logic [fetch_pkg::AW-1:0] pc_inc;
   logic [fetch_pkg::AW-1:0] pc_nxt;

   // Next window with wrap
   always_comb begin
      pc_inc = pc + fetch_pkg::WIN_BYTES;
      if (pc_inc == REGION_END)
         pc_inc = fetch_pkg::RESET_PC;
   end

   always_comb begin
      if (stall_i)
         pc_nxt = pc;   // Hold, stage 1 looks up the stalled window again
      else
         pc_nxt = pc_inc;
   end

   always_ff @(posedge clk) begin
      if (rst_i)
         pc <= PC_INIT;
      else
         pc <= pc_nxt;
   end

   // Window aligned by construction
   assign fetch_vaddr_o = pc_nxt;

endmodule

//--- logic/icache.sv
// Direct-mapped instruction cache, 32 sets of 32-byte lines
// Index from page offset, tag from the registered page number (identity map)
// Miss refills a whole line with one 4-beat burst, then replays the lookup
// Invalidate hitting a line under refill is held until the last beat
`timescale 1ns/1ps

module icache (
   input  logic                     clk,
   input  logic                     rst_i,
   input  fetch_pkg::fetch_addr_u   fetch_vaddr_i,  // Stage 1 address
   output logic                     stall_o,
   output fetch_pkg::fetch_window_t fbuf_o,
   input  logic                     inv_i,
   input  logic [fetch_pkg::AW-1:0] inv_paddr_i,
   output fetch_pkg::rd_ar_t        ar_o,
   input  logic                     ar_ready_i,
   input  fetch_pkg::rd_r_t         r_i,
   output logic                     r_ready_o
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_REQ,    // Burst request on ar
      S_FILL    // Collecting beats
   } ic_state_e;

   // Arrays
   logic [fetch_pkg::IC_TAG_W-1:0] tag_mem [fetch_pkg::IC_LINES];
   logic [fetch_pkg::BUS_DW-1:0]   data_mem [fetch_pkg::IC_LINES][fetch_pkg::LINE_BEATS];
   logic [fetch_pkg::IC_LINES-1:0] vld_q;

   // Stage 2 registers
   logic                                            s2_vld_q;
   logic [fetch_pkg::AW-fetch_pkg::PAGE_BITS-1:0] ppn_s2;
   logic [fetch_pkg::PAGE_BITS-1:0]               vpo_s2;
   fetch_pkg::fetch_addr_u                          s2_addr;
   logic [fetch_pkg::BEAT_W-1:0]                    s2_beat;
   logic                                            hit;

   // Refill control
   ic_state_e                    state_q;
   logic [fetch_pkg::BEAT_W-1:0] cnt_q;
   fetch_pkg::fetch_addr_u       fill_q;      // Line base under refill
   logic                         inv_pend_q;
   logic                         r_fire;
   logic                         fill_done;

   // Invalidate decode
   fetch_pkg::fetch_addr_u inv_a;
   logic                   inv_fill;          // Targets the line under refill
   logic                   inv_now;

   // Stage 1, page offset and page number registered together
   always_ff @(posedge clk) begin
      if (rst_i)
         s2_vld_q <= 1'b0;
      else
         s2_vld_q <= 1'b1;   // Fetch every cycle, stall replays
   end

   always_ff @(posedge clk) begin
      ppn_s2 <= fetch_vaddr_i.pg.ppn;
      vpo_s2 <= fetch_vaddr_i.pg.vpo;
   end

   // Stage 2, physical address rebuilt and seen through the cache view
   assign s2_addr = {ppn_s2, vpo_s2};
   assign s2_beat = s2_addr.ic.off[fetch_pkg::IC_OFF_W-1:fetch_pkg::WIN_OFF_W];
   assign hit     = s2_vld_q && vld_q[s2_addr.ic.idx] &&
                    (tag_mem[s2_addr.ic.idx] == s2_addr.ic.tag);

   always_comb begin
      fbuf_o.valid = (state_q == S_IDLE) && hit;
      fbuf_o.addr  = s2_addr;
      fbuf_o.insn  = data_mem[s2_addr.ic.idx][s2_beat];
   end

   // Stall on a fresh miss and for the whole refill
   assign stall_o = (state_q != S_IDLE) || (s2_vld_q && !hit);

   // Bus side
   always_comb begin
      ar_o.valid = (state_q == S_REQ);
      ar_o.addr  = fill_q;
      ar_o.len   = fetch_pkg::LAST_BEAT;
      ar_o.id    = fetch_pkg::ID_FETCH;
   end

   assign r_ready_o = (state_q == S_FILL);
   assign r_fire    = r_i.valid && r_ready_o;
   assign fill_done = r_fire && r_i.last;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q <= S_IDLE;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            S_IDLE: if (s2_vld_q && !hit) state_q <= S_REQ;
            S_REQ:  if (ar_ready_i) state_q <= S_FILL;
            S_FILL: if (fill_done) state_q <= S_IDLE;   // Replay hits next cycle
            default: state_q <= S_IDLE;
         endcase
         if (fill_done)
            cnt_q <= '0;
         else if (r_fire)
            cnt_q <= cnt_q + 1'b1;
      end
   end

   // Line base latched at miss time
   always_ff @(posedge clk) begin
      if ((state_q == S_IDLE) && s2_vld_q && !hit)
         fill_q <= {s2_addr.ic.tag, s2_addr.ic.idx, {fetch_pkg::IC_OFF_W{1'b0}}};
   end

   // Beats and tag into the arrays
   always_ff @(posedge clk) begin
      if (r_fire)
         data_mem[fill_q.ic.idx][cnt_q] <= r_i.data;
      if (fill_done)
         tag_mem[fill_q.ic.idx] <= fill_q.ic.tag;
   end

   // Invalidate by physical address
   assign inv_a    = inv_paddr_i;
   assign inv_fill = inv_i && (state_q != S_IDLE) &&
                     (inv_a.ic.idx == fill_q.ic.idx) && (inv_a.ic.tag == fill_q.ic.tag);
   assign inv_now  = inv_i && !inv_fill && (tag_mem[inv_a.ic.idx] == inv_a.ic.tag);

   always_ff @(posedge clk) begin
      if (rst_i) begin
         vld_q      <= '0;
         inv_pend_q <= 1'b0;
      end else begin
         if (fill_done)
            vld_q[fill_q.ic.idx] <= !(inv_pend_q || inv_fill);   // Deferred clear
         if (inv_now)
            vld_q[inv_a.ic.idx] <= 1'b0;
         if (fill_done)
            inv_pend_q <= 1'b0;
         else if (inv_fill)
            inv_pend_q <= 1'b1;
      end
   end

   // Fetch beats routed here only while a burst is open
   a_beat_in_fill : assert property (@(posedge clk) disable iff (rst_i)
      r_i.valid |-> (state_q == S_FILL));

   // Memory closes the burst on the fourth beat
   a_last_on_count : assert property (@(posedge clk) disable iff (rst_i)
      r_fire |-> (r_i.last == (cnt_q == fetch_pkg::LAST_BEAT)));

endmodule

//--- logic/uncached_load.sv
// Uncached single-beat load port, one request outstanding
// Requests while busy are ignored, address is aligned down to 8 bytes
`timescale 1ns/1ps

module uncached_load (
   input  logic                         clk,
   input  logic                         rst_i,
   input  logic                         ld_req_i,    // One-cycle pulse
   input  logic [fetch_pkg::AW-1:0]     ld_addr_i,
   output logic                         ld_busy_o,
   output logic                         ld_done_o,
   output logic [fetch_pkg::BUS_DW-1:0] ld_data_o,
   output fetch_pkg::rd_ar_t            ar_o,
   input  logic                         ar_ready_i,
   input  fetch_pkg::rd_r_t             r_i,
   output logic                         r_ready_o
);

   logic                         busy_q;
   logic                         ar_pend_q;   // ar not yet accepted
   logic                         done_q;
   logic [fetch_pkg::AW-1:0]     addr_q;
   logic [fetch_pkg::BUS_DW-1:0] data_q;
   logic                         r_fire;

   assign r_ready_o = busy_q && !ar_pend_q;   // Wait for the beat after ar
   assign r_fire    = r_i.valid && r_ready_o;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         busy_q    <= 1'b0;
         ar_pend_q <= 1'b0;
         done_q    <= 1'b0;
      end else begin
         done_q <= r_fire;   // Pulse with the captured data
         if (ld_req_i && !busy_q) begin
            busy_q    <= 1'b1;
            ar_pend_q <= 1'b1;
         end else begin
            if (ar_pend_q && ar_ready_i)
               ar_pend_q <= 1'b0;
            if (r_fire)
               busy_q <= 1'b0;   // Falls with done
         end
      end
   end

   // Payload
   always_ff @(posedge clk) begin
      if (ld_req_i && !busy_q)
         addr_q <= {ld_addr_i[fetch_pkg::AW-1:fetch_pkg::WIN_OFF_W],
                    {fetch_pkg::WIN_OFF_W{1'b0}}};
      if (r_fire)
         data_q <= r_i.data;
   end

   always_comb begin
      ar_o.valid = ar_pend_q;
      ar_o.addr  = addr_q;
      ar_o.len   = '0;   // Single beat
      ar_o.id    = fetch_pkg::ID_LOAD;
   end

   assign ld_busy_o = busy_q;
   assign ld_done_o = done_q;
   assign ld_data_o = data_q;

   // Caller waits for busy to drop
   a_no_req_busy : assert property (@(posedge clk) disable iff (rst_i)
      ld_req_i |-> !ld_busy_o);

endmodule

//--- logic/rd_bus_arbiter.sv
// Two-master read-bus arbiter, icache and uncached load
// Round-robin on ties, grant held while ar is stalled
// Responses steered by id, memory must answer in order
`timescale 1ns/1ps

module rd_bus_arbiter (
   input  logic              clk,
   input  logic              rst_i,
   input  fetch_pkg::rd_ar_t ic_ar_i,
   output logic              ic_ar_ready_o,
   input  fetch_pkg::rd_ar_t ld_ar_i,
   output logic              ld_ar_ready_o,
   output fetch_pkg::rd_r_t  ic_r_o,
   output fetch_pkg::rd_r_t  ld_r_o,
   input  logic              ic_r_ready_i,
   input  logic              ld_r_ready_i,
   output fetch_pkg::rd_ar_t ar_o,
   input  logic              ar_ready_i,
   input  fetch_pkg::rd_r_t  r_i,
   output logic              r_ready_o
);

   logic [fetch_pkg::ID_W-1:0] gnt_id;       // Current owner of ar
   logic [fetch_pkg::ID_W-1:0] last_id_q;    // Owner of the last accepted ar
   logic [fetch_pkg::ID_W-1:0] lock_id_q;
   logic                       lock_q;       // ar was offered but not taken

   // Grant select
   always_comb begin
      if (lock_q)
         gnt_id = lock_id_q;   // Keep ar stable until accepted
      else if (ic_ar_i.valid && ld_ar_i.valid)
         gnt_id = (last_id_q == fetch_pkg::ID_FETCH) ? fetch_pkg::ID_LOAD
                                                     : fetch_pkg::ID_FETCH;
      else if (ld_ar_i.valid)
         gnt_id = fetch_pkg::ID_LOAD;
      else
         gnt_id = fetch_pkg::ID_FETCH;   // Idle bus shows icache side
   end

   assign ar_o          = (gnt_id == fetch_pkg::ID_LOAD) ? ld_ar_i : ic_ar_i;
   assign ic_ar_ready_o = ar_ready_i && (gnt_id == fetch_pkg::ID_FETCH);
   assign ld_ar_ready_o = ar_ready_i && (gnt_id == fetch_pkg::ID_LOAD);

   always_ff @(posedge clk) begin
      if (rst_i) begin
         lock_q    <= 1'b0;
         lock_id_q <= fetch_pkg::ID_FETCH;
         last_id_q <= fetch_pkg::ID_LOAD;   // First tie goes to fetch
      end else begin
         lock_q    <= ar_o.valid && !ar_ready_i;
         lock_id_q <= gnt_id;
         if (ar_o.valid && ar_ready_i)
            last_id_q <= gnt_id;
      end
   end

   // Return path by id
   always_comb begin
      ic_r_o       = r_i;
      ic_r_o.valid = r_i.valid && (r_i.id == fetch_pkg::ID_FETCH);
      ld_r_o       = r_i;
      ld_r_o.valid = r_i.valid && (r_i.id == fetch_pkg::ID_LOAD);
   end

   assign r_ready_o = (r_i.id == fetch_pkg::ID_LOAD) ? ld_r_ready_i : ic_r_ready_i;

   // Stalled request must not change under the slave
   a_ar_stable : assert property (@(posedge clk) disable iff (rst_i)
      (ar_o.valid && !ar_ready_i) |=> $stable(ar_o));

endmodule

//--- logic/fetch_subsys.sv
// Fetch subsystem top, PC generator, I-cache, uncached load port
// One shared read bus out, ar/r valid-ready only, no write channel
`timescale 1ns/1ps

module fetch_subsys (
   input  logic                         clk,
   input  logic                         rst_i,
   output fetch_pkg::fetch_window_t     fbuf_o,
   input  logic                         inv_i,
   input  logic [fetch_pkg::AW-1:0]     inv_paddr_i,
   input  logic                         ld_req_i,
   input  logic [fetch_pkg::AW-1:0]     ld_addr_i,
   output logic                         ld_busy_o,
   output logic                         ld_done_o,
   output logic [fetch_pkg::BUS_DW-1:0] ld_data_o,
   output fetch_pkg::rd_ar_t            ar_o,
   input  logic                         ar_ready_i,
   input  fetch_pkg::rd_r_t             r_i,
   output logic                         r_ready_o
);

   fetch_pkg::fetch_addr_u fetch_vaddr;
   logic                   ic_stall;
   fetch_pkg::rd_ar_t      ic_ar;
   fetch_pkg::rd_ar_t      ld_ar;
   logic                   ic_ar_ready;
   logic                   ld_ar_ready;
   fetch_pkg::rd_r_t       ic_r;
   fetch_pkg::rd_r_t       ld_r;
   logic                   ic_r_ready;
   logic                   ld_r_ready;

   fetch_pc_gen u_pc_gen (
      .clk           (clk),
      .rst_i         (rst_i),
      .stall_i       (ic_stall),
      .fetch_vaddr_o (fetch_vaddr)
   );

   icache u_icache (
      .clk           (clk),
      .rst_i         (rst_i),
      .fetch_vaddr_i (fetch_vaddr),
      .stall_o       (ic_stall),
      .fbuf_o        (fbuf_o),
      .inv_i         (inv_i),
      .inv_paddr_i   (inv_paddr_i),
      .ar_o          (ic_ar),
      .ar_ready_i    (ic_ar_ready),
      .r_i           (ic_r),
      .r_ready_o     (ic_r_ready)
   );

   uncached_load u_uncached_load (
      .clk        (clk),
      .rst_i      (rst_i),
      .ld_req_i   (ld_req_i),
      .ld_addr_i  (ld_addr_i),
      .ld_busy_o  (ld_busy_o),
      .ld_done_o  (ld_done_o),
      .ld_data_o  (ld_data_o),
      .ar_o       (ld_ar),
      .ar_ready_i (ld_ar_ready),
      .r_i        (ld_r),
      .r_ready_o  (ld_r_ready)
   );

   rd_bus_arbiter u_arbiter (
      .clk           (clk),
      .rst_i         (rst_i),
      .ic_ar_i       (ic_ar),
      .ic_ar_ready_o (ic_ar_ready),
      .ld_ar_i       (ld_ar),
      .ld_ar_ready_o (ld_ar_ready),
      .ic_r_o        (ic_r),
      .ld_r_o        (ld_r),
      .ic_r_ready_i  (ic_r_ready),
      .ld_r_ready_i  (ld_r_ready),
      .ar_o          (ar_o),
      .ar_ready_i    (ar_ready_i),
      .r_i           (r_i),
      .r_ready_o     (r_ready_o)
   );

endmodule

//--- tb/mem_model.sv
// Read-bus memory for the fetch testbench, one burst at a time, in order
// Word at an 8-byte address is {addr, addr ^ version of its 32-byte line}
// Random ready and valid gaps come from the testbench's xorshift word
`timescale 1ns/1ps

module mem_model (
   input  logic                           clk,
   input  logic                           rst_i,
   input  logic [31:0]                    rnd_i,         // New word every falling edge
   input  fetch_pkg::rd_ar_t              ar_i,
   output logic                           ar_ready_o,
   output fetch_pkg::rd_r_t               r_o,
   input  logic                           r_ready_i,
   input  logic                           bump_i,        // New version for one line
   input  logic [fetch_pkg::IC_IDX_W-1:0] bump_line_i,
   output int unsigned                    fetch_bursts_o,
   output int unsigned                    load_bursts_o
);

   logic [31:0] line_ver [fetch_pkg::REGION_BYTES / fetch_pkg::LINE_BYTES];

   // Handshakes seen on the rising edge
   logic              ar_fire;
   fetch_pkg::rd_ar_t ar_cap;
   logic              r_fire;

   // Burst state, owned by the falling-edge block
   logic                          busy;
   logic [fetch_pkg::AW-1:0]      base;
   logic [fetch_pkg::BEAT_W-1:0]  len;
   logic [fetch_pkg::BEAT_W-1:0]  beat;
   logic [fetch_pkg::ID_W-1:0]    id;
   logic [fetch_pkg::AW-1:0]      beat_addr;
   logic                          r_valid;

   function automatic logic [fetch_pkg::IC_IDX_W-1:0] line_index(
      input logic [fetch_pkg::AW-1:0] addr);
      logic [fetch_pkg::AW-1:0] rel;
      rel = (addr - fetch_pkg::RESET_PC) / fetch_pkg::LINE_BYTES;
      return rel[fetch_pkg::IC_IDX_W-1:0];   // Region is 32 lines
   endfunction

   function automatic logic [63:0] beat_word(input logic [31:0] addr, input logic [31:0] ver);
      return {addr, addr ^ ver};
   endfunction

   always @(posedge clk) begin
      if (rst_i) begin
         for (int i = 0; i < 32; i++)
            line_ver[i] <= 32'h5a00_0000 + i;   // Distinct start per line
         ar_fire <= 1'b0;
         r_fire  <= 1'b0;
      end else begin
         ar_fire <= ar_i.valid && ar_ready_o;
         ar_cap  <= ar_i;
         r_fire  <= r_o.valid && r_ready_i;
         if (bump_i)
            line_ver[bump_line_i] <= line_ver[bump_line_i] + 32'h0001_0000;
      end
   end

   // State update and new outputs on the falling edge
   always @(negedge clk) begin
      if (rst_i) begin
         busy           = 1'b0;
         beat           = '0;
         ar_ready_o     <= 1'b0;
         r_o            <= '0;
         fetch_bursts_o <= 0;
         load_bursts_o  <= 0;
      end else begin
         if (ar_fire) begin
            busy = 1'b1;
            base = ar_cap.addr;
            len  = ar_cap.len;
            id   = ar_cap.id;
            beat = '0;
            if (ar_cap.id == fetch_pkg::ID_LOAD)
               load_bursts_o <= load_bursts_o + 1;
            else
               fetch_bursts_o <= fetch_bursts_o + 1;
         end
         if (r_fire) begin
            if (beat == len)
               busy = 1'b0;   // Burst closed
            else
               beat = beat + 1'b1;
         end
         ar_ready_o <= !busy && (rnd_i[1:0] != 2'b00);
         // Beat not taken stays up, otherwise random gap
         r_valid   = busy && ((r_o.valid && !r_fire) || (rnd_i[3:2] != 2'b00));
         beat_addr = base + 32'(beat) * fetch_pkg::WIN_BYTES;
         r_o.valid <= r_valid;
         r_o.data  <= beat_word(beat_addr, line_ver[line_index(beat_addr)]);
         r_o.last  <= (beat == len);
         r_o.id    <= id;
      end
   end

endmodule

//--- tb/fetch_subsys_tb.sv
// Fetch subsystem testbench, fetch order, refill counts, invalidate and loads
// Memory word is {addr, addr ^ line version}, version bumped on invalidate
// Loads run only before the invalidate step, so their versions are fixed
`timescale 1ns/1ps

module fetch_subsys_tb;

   logic                           clk;
   logic                           rst_i;
   logic [31:0]                    rnd;          // Xorshift stream
   fetch_pkg::fetch_window_t       fbuf;
   logic                           inv_i;
   logic [fetch_pkg::AW-1:0]       inv_paddr_i;
   logic                           ld_req_i;
   logic [fetch_pkg::AW-1:0]       ld_addr_i;
   logic                           ld_busy;
   logic                           ld_done;
   logic [fetch_pkg::BUS_DW-1:0]   ld_data;
   fetch_pkg::rd_ar_t              ar;
   logic                           ar_ready;
   fetch_pkg::rd_r_t               r;
   logic                           r_ready;
   logic                           bump;
   logic [fetch_pkg::IC_IDX_W-1:0] bump_line;
   int unsigned                    fetch_bursts;
   int unsigned                    load_bursts;

   // Expected side
   int                             win_cnt;      // Windows delivered so far
   logic [fetch_pkg::AW-1:0]       exp_addr;
   logic [fetch_pkg::BUS_DW-1:0]   exp_insn;
   logic [fetch_pkg::AW-1:0]       ld_exp_addr;
   logic [fetch_pkg::BUS_DW-1:0]   exp_ld;
   logic                           check_bursts;
   int unsigned                    want_bursts;
   logic                           check_loads;
   int unsigned                    want_loads;
   int unsigned                    load_total;
   int                             inv_win;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [fetch_pkg::IC_IDX_W-1:0] line_of(
      input logic [fetch_pkg::AW-1:0] addr);
      logic [fetch_pkg::AW-1:0] rel;
      rel = (addr - fetch_pkg::RESET_PC) / fetch_pkg::LINE_BYTES;
      return rel[fetch_pkg::IC_IDX_W-1:0];
   endfunction

   function automatic logic [63:0] expected_word(input logic [31:0] addr,
                                                 input logic [31:0] ver);
      return {addr, addr ^ ver};   // Upper lane is the address itself
   endfunction

   fetch_subsys dut_i (
      .clk         (clk),
      .rst_i       (rst_i),
      .fbuf_o      (fbuf),
      .inv_i       (inv_i),
      .inv_paddr_i (inv_paddr_i),
      .ld_req_i    (ld_req_i),
      .ld_addr_i   (ld_addr_i),
      .ld_busy_o   (ld_busy),
      .ld_done_o   (ld_done),
      .ld_data_o   (ld_data),
      .ar_o        (ar),
      .ar_ready_i  (ar_ready),
      .r_i         (r),
      .r_ready_o   (r_ready)
   );

   mem_model mem_i (
      .clk            (clk),
      .rst_i          (rst_i),
      .rnd_i          (rnd),
      .ar_i           (ar),
      .ar_ready_o     (ar_ready),
      .r_o            (r),
      .r_ready_i      (r_ready),
      .bump_i         (bump),
      .bump_line_i    (bump_line),
      .fetch_bursts_o (fetch_bursts),
      .load_bursts_o  (load_bursts)
   );

   // Starts high, memory outputs settle on the first falling edge
   initial begin
      clk = 1'b1;
      forever #5 clk = ~clk;
   end

   always @(negedge clk) begin
      if (rst_i)
         rnd <= 32'hed89_0fb3;
      else
         rnd <= xorshift32(rnd);
   end

   // Expected window address, linear with wrap
   always @(posedge clk) begin
      if (rst_i) begin
         win_cnt  <= 0;
         exp_addr <= fetch_pkg::RESET_PC;
      end else if (fbuf.valid) begin
         win_cnt <= win_cnt + 1;
         if (exp_addr + fetch_pkg::WIN_BYTES == fetch_pkg::RESET_PC + fetch_pkg::REGION_BYTES)
            exp_addr <= fetch_pkg::RESET_PC;
         else
            exp_addr <= exp_addr + fetch_pkg::WIN_BYTES;
      end
   end

   assign exp_insn = expected_word(exp_addr, mem_i.line_ver[line_of(exp_addr)]);
   assign exp_ld   = expected_word(ld_exp_addr, mem_i.line_ver[line_of(ld_exp_addr)]);

   task automatic abort_run(input string line);
      $display("=== FAIL ===");
      $display("%s", line);
      $fatal(1, "testbench stopped at first failure");
   endtask

   a_reset_quiet : assert property (@(posedge clk)
      rst_i |=> (!ar.valid && !r_ready && !fbuf.valid && !ld_busy && !ld_done))
      else abort_run($sformatf("** Error at %0d ns: outputs active after reset", $time));

   a_win_addr : assert property (@(posedge clk) disable iff (rst_i)
      fbuf.valid |-> (fbuf.addr == exp_addr))
      else abort_run($sformatf("** Error at %0d ns: window addr %h, expected %h",
                               $time, fbuf.addr, exp_addr));

   a_win_data : assert property (@(posedge clk) disable iff (rst_i)
      fbuf.valid |-> (fbuf.insn == exp_insn))
      else abort_run($sformatf("** Error at %0d ns: window data %h, expected %h",
                               $time, fbuf.insn, exp_insn));

   a_burst_shape : assert property (@(posedge clk) disable iff (rst_i)
      (ar.valid && ar_ready && (ar.id == fetch_pkg::ID_FETCH)) |->
      ((ar.len == 2'(fetch_pkg::LINE_BEATS - 1)) &&
       (ar.addr % fetch_pkg::LINE_BYTES == 32'd0)))
      else abort_run($sformatf("** Error at %0d ns: fetch burst addr %h len %0d",
                               $time, ar.addr, ar.len));

   a_ar_hold : assert property (@(posedge clk) disable iff (rst_i)
      (ar.valid && !ar_ready) |=> $stable(ar))
      else abort_run($sformatf("** Error at %0d ns: ar changed while held off", $time));

   a_burst_count : assert property (@(posedge clk) disable iff (rst_i)
      check_bursts |-> (fetch_bursts == want_bursts))
      else abort_run($sformatf("** Error at %0d ns: %0d fetch bursts, expected %0d",
                               $time, fetch_bursts, want_bursts));

   a_load_busy : assert property (@(posedge clk) disable iff (rst_i)
      ld_req_i |=> ld_busy)
      else abort_run($sformatf("** Error at %0d ns: load port not busy after request", $time));

   a_load_data : assert property (@(posedge clk) disable iff (rst_i)
      ld_done |-> (ld_data == exp_ld))
      else abort_run($sformatf("** Error at %0d ns: load data %h, expected %h",
                               $time, ld_data, exp_ld));

   a_load_count : assert property (@(posedge clk) disable iff (rst_i)
      check_loads |-> (load_bursts == want_loads))
      else abort_run($sformatf("** Error at %0d ns: %0d load bursts, expected %0d",
                               $time, load_bursts, want_loads));

   task automatic wait_windows(input int target, input int limit);
      int n;
      n = 0;
      while ((win_cnt < target) && (n < limit)) begin
         @(negedge clk);
         n++;
      end
      if (win_cnt < target)
         abort_run($sformatf("Timeout: %0d of %0d fetch windows after %0d cycles",
                             win_cnt, target, limit));
   endtask

   task automatic wait_load_done(input int limit);
      int n;
      n = 0;
      while (!ld_done && (n < limit)) begin
         @(negedge clk);
         n++;
      end
      if (!ld_done)
         abort_run("Timeout: load did not complete");
   endtask

   // Random loads against the running fetch stream
   task automatic run_loads(input int unsigned count);
      int gap;
      for (int unsigned k = 0; k < count; k++) begin
         gap = int'(rnd[30:27]) + 1;
         repeat (gap) @(negedge clk);
         ld_addr_i   = fetch_pkg::RESET_PC + {22'd0, rnd[25:16]};
         ld_exp_addr = ld_addr_i & ~32'h7;   // Aligned down to the window
         ld_req_i    = 1'b1;
         @(negedge clk);
         ld_req_i = 1'b0;
         wait_load_done(500);
      end
   endtask

   task automatic check_burst_count(input int unsigned want);
      want_bursts  = want;
      check_bursts = 1'b1;
      @(negedge clk);
      check_bursts = 1'b0;
   endtask

   task automatic check_load_count(input int unsigned want);
      want_loads  = want;
      check_loads = 1'b1;
      @(negedge clk);
      check_loads = 1'b0;
   endtask

   // New line content in memory, then drop the cached copy
   task automatic invalidate_line(input logic [fetch_pkg::AW-1:0] addr);
      bump        = 1'b1;
      bump_line   = line_of(addr);
      inv_i       = 1'b1;
      inv_paddr_i = addr;
      @(negedge clk);
      bump  = 1'b0;
      inv_i = 1'b0;
   endtask

   initial begin
      rst_i        = 1'b1;
      inv_i        = 1'b0;
      inv_paddr_i  = '0;
      ld_req_i     = 1'b0;
      ld_addr_i    = '0;
      ld_exp_addr  = '0;
      bump         = 1'b0;
      bump_line    = '0;
      check_bursts = 1'b0;
      want_bursts  = 0;
      check_loads  = 1'b0;
      want_loads   = 0;
      load_total   = 12;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_i <= 1'b0;   // Falling-edge blocks still see reset this edge

      fork
         run_loads(load_total);
         begin
            wait_windows(128, 20000);    // First pass, every line misses once
            check_burst_count(32);
            wait_windows(256, 20000);    // Second pass, all hits
            check_burst_count(32);
         end
      join
      check_load_count(load_total);

      inv_win = win_cnt;
      invalidate_line(fetch_pkg::RESET_PC + {22'd0, rnd[9:0]});
      wait_windows(inv_win + 256, 20000);
      check_burst_count(33);

      $display("=== PASS ===");
      $finish;
   end

endmodule

//--- fetch_subsys.f
logic/fetch_pkg.sv
logic/fetch_pc_gen.sv
logic/icache.sv
logic/uncached_load.sv
logic/rd_bus_arbiter.sv
logic/fetch_subsys.sv
tb/mem_model.sv
tb/fetch_subsys_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the fetch subsystem testbench with Verilator
# Exit status is nonzero if the build fails or the testbench stops with $fatal
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
   --top-module fetch_subsys_tb -f fetch_subsys.f -o fetch_subsys_sim &&
./obj_dir/fetch_subsys_sim ||
{ echo "simulation run failed" >&2; exit 1; }
